// File: design/boot_rom.sv
// ------------------------------
// Boot ROM
// Fixed table of tagged words, one-cycle read
// ------------------------------
module boot_rom (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  logic [harness_pkg::ROM_IDX_W-1:0]  idx_i,
  output logic [harness_pkg::DATA_W-1:0]     rdata_o
);

  localparam int unsigned HalfW = harness_pkg::DATA_W / 2;

  logic [harness_pkg::DATA_W-1:0] rom_words [harness_pkg::ROM_WORDS];
  logic [harness_pkg::DATA_W-1:0] rdata_q;

  // Tag in the upper half, word index in the lower half
  for (genvar i = 0; i < harness_pkg::ROM_WORDS; i++) begin : g_words
    assign rom_words[i] = {harness_pkg::ROM_TAG, HalfW'(i)};
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= rom_words[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: design/bus_router.sv
// ------------------------------
// Bus router
// Decodes one request at a time, strobes the target
// and returns a registered response
// ------------------------------
module bus_router (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_valid_i,
  input  logic [harness_pkg::ADDR_W-1:0]      req_addr_i,
  input  logic                                req_we_i,
  input  logic [harness_pkg::BE_W-1:0]        req_be_i,
  input  logic [harness_pkg::DATA_W-1:0]      req_wdata_i,
  input  logic                                rsp_ready_i,
  input  logic [harness_pkg::DATA_W-1:0]      rom_rdata_i,
  input  logic [harness_pkg::DATA_W-1:0]      sram_rdata_i,
  output logic                                req_ready_o,
  output logic                                rsp_valid_o,
  output logic [harness_pkg::DATA_W-1:0]      rsp_rdata_o,
  output logic [harness_pkg::RESP_W-1:0]      rsp_err_o,
  output logic                                rom_req_o,
  output logic [harness_pkg::ROM_IDX_W-1:0]   rom_idx_o,
  output logic                                sram_req_o,
  output logic                                sram_we_o,
  output logic [harness_pkg::SRAM_IDX_W-1:0]  sram_idx_o,
  output logic [harness_pkg::BE_W-1:0]        sram_be_o,
  output logic [harness_pkg::DATA_W-1:0]      sram_wdata_o
);

  logic [harness_pkg::ST_W-1:0]   state_q, state_d;
  logic [harness_pkg::TGT_W-1:0]  tgt_q, tgt_d;
  logic [harness_pkg::RESP_W-1:0] err_q, err_d;
  logic                           rd_q;
  logic [1:0]                     init_q;
  logic [harness_pkg::DATA_W-1:0] rdata_q, rdata_sel;
  logic [harness_pkg::ADDR_W-1:0] rom_off, sram_off, gpio_off;
  logic                           rom_hit, sram_hit, gpio_hit;
  logic                           xfer;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign rom_off  = req_addr_i - harness_pkg::ROM_BASE;
  assign sram_off = req_addr_i - harness_pkg::SRAM_BASE;
  assign gpio_off = req_addr_i - harness_pkg::GPIO_BASE;

  assign rom_hit  = rom_off < harness_pkg::ROM_LEN;
  assign sram_hit = sram_off < harness_pkg::SRAM_LEN;
  assign gpio_hit = gpio_off < harness_pkg::GPIO_LEN;

  always_comb begin
    tgt_d = harness_pkg::TGT_NONE;
    err_d = harness_pkg::RESP_DECERR;
    if (rom_hit) begin
      // ROM is read-only
      if (req_we_i) begin
        err_d = harness_pkg::RESP_SLVERR;
      end else begin
        tgt_d = harness_pkg::TGT_ROM;
        err_d = harness_pkg::RESP_OKAY;
      end
    end else if (sram_hit) begin
      tgt_d = harness_pkg::TGT_SRAM;
      err_d = harness_pkg::RESP_OKAY;
    end else if (gpio_hit) begin
      err_d = harness_pkg::RESP_SLVERR;
    end
  end

  // Ready held off for two cycles after reset release
  assign req_ready_o = (state_q == harness_pkg::ST_IDLE) && init_q[1];
  assign xfer        = req_valid_i && req_ready_o;

  // Target strobes issued in the transfer cycle
  assign rom_req_o    = xfer && (tgt_d == harness_pkg::TGT_ROM);
  assign rom_idx_o    = req_addr_i[harness_pkg::BYTE_OFF_W +: harness_pkg::ROM_IDX_W];
  assign sram_req_o   = xfer && (tgt_d == harness_pkg::TGT_SRAM);
  assign sram_we_o    = req_we_i;
  assign sram_idx_o   = req_addr_i[harness_pkg::BYTE_OFF_W +: harness_pkg::SRAM_IDX_W];
  assign sram_be_o    = req_be_i;
  assign sram_wdata_o = req_wdata_i;

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      harness_pkg::ST_IDLE: begin
        if (xfer) begin
          state_d = harness_pkg::ST_ACCESS;
        end
      end
      harness_pkg::ST_ACCESS: state_d = harness_pkg::ST_RESPOND;
      harness_pkg::ST_RESPOND: begin
        if (rsp_ready_i) begin
          state_d = harness_pkg::ST_IDLE;
        end
      end
      default: state_d = harness_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= harness_pkg::ST_IDLE;
      tgt_q   <= harness_pkg::TGT_NONE;
      err_q   <= harness_pkg::RESP_OKAY;
      rd_q    <= 1'b0;
      init_q  <= 2'b00;
    end else begin
      state_q <= state_d;
      init_q  <= {init_q[0], 1'b1};
      if (xfer) begin
        tgt_q <= tgt_d;
        err_q <= err_d;
        rd_q  <= !req_we_i;
      end
    end
  end

  // Errors and writes carry zero data
  always_comb begin
    rdata_sel = '0;
    if (rd_q && (tgt_q == harness_pkg::TGT_ROM)) begin
      rdata_sel = rom_rdata_i;
    end else if (rd_q && (tgt_q == harness_pkg::TGT_SRAM)) begin
      rdata_sel = sram_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == harness_pkg::ST_ACCESS) begin
      rdata_q <= rdata_sel;
    end
  end

  assign rsp_valid_o = (state_q == harness_pkg::ST_RESPOND);
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

endmodule

// File: design/debug_ctrl.sv
// ------------------------------
// Debug control
// System reset synchronizer and debug request gate
// ------------------------------
module debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic sys_rst_no,
  output logic debug_req_o
);

  logic                              sync_rst_n;
  logic [1:0]                        sync_q;
  logic [harness_pkg::DBG_CNT_W-1:0] dly_cnt_q;

  // ------------------------------
  // Reset synchronizer
  // ------------------------------
  // Asserts at once, releases after two edges
  assign sync_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  // ------------------------------
  // Debug delay window
  // ------------------------------
  // Power-on reset only, survives ndmreset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_cnt_q <= harness_pkg::DBG_CNT_W'(harness_pkg::DEBUG_DELAY_CYCLES);
    end else if (dly_cnt_q != '0) begin
      dly_cnt_q <= dly_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (dly_cnt_q == '0) && debug_en_i && debug_req_i;

endmodule

// File: design/harness_pkg.sv
// ------------------------------
// Harness package
// Address map, bus widths, response codes and timing constants
// ------------------------------
package harness_pkg;

  // Bus widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned BYTE_OFF_W = $clog2(BE_W);
  localparam int unsigned RESP_W     = 2;

  // Response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam logic [ADDR_W-1:0] ROM_BASE   = 32'h0001_0000;
  localparam int unsigned       ROM_WORDS  = 16;
  localparam int unsigned       ROM_IDX_W  = $clog2(ROM_WORDS);
  localparam logic [ADDR_W-1:0] ROM_LEN    = ADDR_W'(ROM_WORDS * BE_W);
  localparam logic [15:0]       ROM_TAG    = 16'hB007;

  localparam logic [ADDR_W-1:0] SRAM_BASE  = 32'h8000_0000;
  localparam int unsigned       SRAM_WORDS = 1024;
  localparam int unsigned       SRAM_IDX_W = $clog2(SRAM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_LEN   = ADDR_W'(SRAM_WORDS * BE_W);

  // Unimplemented peripheral window
  localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] GPIO_LEN   = 32'h1000;

  // Debug gating after power-on
  localparam int unsigned DEBUG_DELAY_CYCLES = 20;
  localparam int unsigned DBG_CNT_W          = $clog2(DEBUG_DELAY_CYCLES + 1);

  // Router FSM states
  localparam int unsigned   ST_W       = 2;
  localparam logic [ST_W-1:0] ST_IDLE    = 2'd0;
  localparam logic [ST_W-1:0] ST_ACCESS  = 2'd1;
  localparam logic [ST_W-1:0] ST_RESPOND = 2'd2;

  // Router target select
  localparam int unsigned      TGT_W    = 2;
  localparam logic [TGT_W-1:0] TGT_NONE = 2'd0;
  localparam logic [TGT_W-1:0] TGT_ROM  = 2'd1;
  localparam logic [TGT_W-1:0] TGT_SRAM = 2'd2;

endpackage

// File: design/soc_harness_top.sv
// ------------------------------
// SoC memory harness top
// Router, boot ROM, SRAM and debug control
// ------------------------------
module soc_harness_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                ndmreset_i,
  input  logic                                req_valid_i,
  input  logic [harness_pkg::ADDR_W-1:0]      req_addr_i,
  input  logic                                req_we_i,
  input  logic [harness_pkg::BE_W-1:0]        req_be_i,
  input  logic [harness_pkg::DATA_W-1:0]      req_wdata_i,
  input  logic                                rsp_ready_i,
  input  logic                                debug_req_i,
  input  logic                                debug_en_i,
  output logic                                req_ready_o,
  output logic                                rsp_valid_o,
  output logic [harness_pkg::DATA_W-1:0]      rsp_rdata_o,
  output logic [harness_pkg::RESP_W-1:0]      rsp_err_o,
  output logic                                debug_req_o
);

  logic                                  sys_rst_n;

  logic                                  rom_req;
  logic [harness_pkg::ROM_IDX_W-1:0]     rom_idx;
  logic [harness_pkg::DATA_W-1:0]        rom_rdata;

  logic                                  sram_req;
  logic                                  sram_we;
  logic [harness_pkg::SRAM_IDX_W-1:0]    sram_idx;
  logic [harness_pkg::BE_W-1:0]          sram_be;
  logic [harness_pkg::DATA_W-1:0]        sram_wdata;
  logic [harness_pkg::DATA_W-1:0]        sram_rdata;

  // ------------------------------
  // Reset and debug
  // ------------------------------
  debug_ctrl i_debug_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .sys_rst_no  ( sys_rst_n   ),
    .debug_req_o ( debug_req_o )
  );

  // ------------------------------
  // Bus and targets
  // ------------------------------
  bus_router i_bus_router (
    .clk_i        ( clk_i       ),
    .rst_ni       ( sys_rst_n   ),
    .req_valid_i  ( req_valid_i ),
    .req_addr_i   ( req_addr_i  ),
    .req_we_i     ( req_we_i    ),
    .req_be_i     ( req_be_i    ),
    .req_wdata_i  ( req_wdata_i ),
    .rsp_ready_i  ( rsp_ready_i ),
    .rom_rdata_i  ( rom_rdata   ),
    .sram_rdata_i ( sram_rdata  ),
    .req_ready_o  ( req_ready_o ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_rdata_o  ( rsp_rdata_o ),
    .rsp_err_o    ( rsp_err_o   ),
    .rom_req_o    ( rom_req     ),
    .rom_idx_o    ( rom_idx     ),
    .sram_req_o   ( sram_req    ),
    .sram_we_o    ( sram_we     ),
    .sram_idx_o   ( sram_idx    ),
    .sram_be_o    ( sram_be     ),
    .sram_wdata_o ( sram_wdata  )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .rst_ni  ( sys_rst_n ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  // Contents kept across a non-debug reset
  sram_mem i_sram_mem (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .idx_i   ( sram_idx   ),
    .be_i    ( sram_be    ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

endmodule

// File: design/sram_mem.sv
// ------------------------------
// SRAM
// Word memory with byte-enable writes and a one-cycle read
// ------------------------------
module sram_mem (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [harness_pkg::SRAM_IDX_W-1:0]  idx_i,
  input  logic [harness_pkg::BE_W-1:0]        be_i,
  input  logic [harness_pkg::DATA_W-1:0]      wdata_i,
  output logic [harness_pkg::DATA_W-1:0]      rdata_o
);

  logic [harness_pkg::DATA_W-1:0] mem_q [harness_pkg::SRAM_WORDS];
  logic [harness_pkg::DATA_W-1:0] rdata_q;

  // Byte lanes written independently
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < harness_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data only updates on a read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: dv/clk_gen.sv
// ------------------------------
// Testbench clock
// Free-running clock with a period of 4
// ------------------------------
module clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

// File: dv/soc_harness_asserts.sv
// ------------------------------
// Harness assertions
// Response stability, ready/valid exclusion and debug gating
// ------------------------------
module soc_harness_asserts (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic                                req_ready_i,
  input logic                                rsp_valid_i,
  input logic                                rsp_ready_i,
  input logic [harness_pkg::DATA_W-1:0]      rsp_rdata_i,
  input logic [harness_pkg::RESP_W-1:0]      rsp_err_i,
  input logic [harness_pkg::DBG_CNT_W-1:0]   dly_cnt_i,
  input logic                                debug_gated_i
);

  // Response held while the master stalls
  rsp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i))
    else $error("Response changed while stalled");

  // One transaction in flight
  ready_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_ready_i && rsp_valid_i))
    else $error("Request ready while a response is pending");

  debug_gate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dly_cnt_i != '0) |-> !debug_gated_i)
    else $error("Debug request passed inside the delay window");

endmodule

bind bus_router soc_harness_asserts u_router_asserts (
  .clk_i         ( clk_i       ),
  .rst_ni        ( rst_ni      ),
  .req_ready_i   ( req_ready_o ),
  .rsp_valid_i   ( rsp_valid_o ),
  .rsp_ready_i   ( rsp_ready_i ),
  .rsp_rdata_i   ( rsp_rdata_o ),
  .rsp_err_i     ( rsp_err_o   ),
  .dly_cnt_i     ( '0          ),
  .debug_gated_i ( 1'b0        )
);

bind debug_ctrl soc_harness_asserts u_debug_asserts (
  .clk_i         ( clk_i       ),
  .rst_ni        ( rst_ni      ),
  .req_ready_i   ( 1'b0        ),
  .rsp_valid_i   ( 1'b0        ),
  .rsp_ready_i   ( 1'b1        ),
  .rsp_rdata_i   ( '0          ),
  .rsp_err_i     ( '0          ),
  .dly_cnt_i     ( dly_cnt_q   ),
  .debug_gated_i ( debug_req_o )
);

// File: dv/tb_soc_harness.sv
// ------------------------------
// SoC harness testbench
// Table-driven bus traffic, debug gating and ndmreset checks
// ------------------------------
module tb_soc_harness;

  localparam int unsigned MaxEntries    = 40;
  localparam int unsigned RspLatency    = 2;
  // Two synchronizer edges, then two more before ready
  localparam int unsigned ReleaseEdges  = 4;

  logic        clk;
  logic        rst_n;
  logic        ndmreset;
  logic        req_valid;
  logic [31:0] req_addr;
  logic        req_we;
  logic [3:0]  req_be;
  logic [31:0] req_wdata;
  logic        rsp_ready;
  logic        debug_req;
  logic        debug_en;
  logic        req_ready;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;
  logic [1:0]  rsp_err;
  logic        debug_req_out;

  // Stimulus table with expected responses
  logic [31:0] tbl_addr     [MaxEntries];
  logic        tbl_we       [MaxEntries];
  logic [3:0]  tbl_be       [MaxEntries];
  logic [31:0] tbl_wdata    [MaxEntries];
  logic [31:0] tbl_exp_data [MaxEntries];
  logic [1:0]  tbl_exp_resp [MaxEntries];
  int          n_entries   = 0;
  int          reset_at    = 0;
  bit          table_ready = 1'b0;
  int          seed        = 32'h5c26;

  logic [31:0] sram_model [int unsigned];

  clk_gen u_clk_gen (
    .clk_o ( clk )
  );

  soc_harness_top DUT (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .ndmreset_i  ( ndmreset      ),
    .req_valid_i ( req_valid     ),
    .req_addr_i  ( req_addr      ),
    .req_we_i    ( req_we        ),
    .req_be_i    ( req_be        ),
    .req_wdata_i ( req_wdata     ),
    .rsp_ready_i ( rsp_ready     ),
    .debug_req_i ( debug_req     ),
    .debug_en_i  ( debug_en      ),
    .req_ready_o ( req_ready     ),
    .rsp_valid_o ( rsp_valid     ),
    .rsp_rdata_o ( rsp_rdata     ),
    .rsp_err_o   ( rsp_err       ),
    .debug_req_o ( debug_req_out )
  );

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, act, exp);
      $display("TEST FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] rom_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - harness_pkg::ROM_BASE) >> 2;
    return {harness_pkg::ROM_TAG, idx[15:0]};
  endfunction

  task automatic add_entry(input logic [31:0] addr, input logic we, input logic [3:0] be,
                           input logic [31:0] wdata, input logic [1:0] resp);
    int unsigned widx;
    logic [31:0] old_w;
    logic [31:0] exp;
    logic        in_sram;
    exp     = '0;
    in_sram = (addr - harness_pkg::SRAM_BASE) < (harness_pkg::SRAM_WORDS * 4);
    if (resp == harness_pkg::RESP_OKAY && in_sram) begin
      widx = (addr - harness_pkg::SRAM_BASE) >> 2;
      if (we) begin
        old_w = sram_model.exists(widx) ? sram_model[widx] : '0;
        sram_model[widx] = merge_bytes(old_w, wdata, be);
      end else begin
        exp = sram_model[widx];
      end
    end else if (resp == harness_pkg::RESP_OKAY && !we) begin
      exp = rom_word(addr);
    end
    tbl_addr[n_entries]     = addr;
    tbl_we[n_entries]       = we;
    tbl_be[n_entries]       = be;
    tbl_wdata[n_entries]    = wdata;
    tbl_exp_data[n_entries] = exp;
    tbl_exp_resp[n_entries] = resp;
    n_entries++;
  endtask

  task automatic build_table();
    logic [31:0] s;
    logic [31:0] r;
    logic [31:0] g;
    logic [1:0]  ok;
    logic [1:0]  slv;
    logic [1:0]  dec;
    s   = harness_pkg::SRAM_BASE;
    r   = harness_pkg::ROM_BASE;
    g   = harness_pkg::GPIO_BASE;
    ok  = harness_pkg::RESP_OKAY;
    slv = harness_pkg::RESP_SLVERR;
    dec = harness_pkg::RESP_DECERR;
    // SRAM full writes, then partial merges
    add_entry(s,            1'b1, 4'b1111, 32'h1122_3344, ok);
    add_entry(s + 32'h4,    1'b1, 4'b1111, 32'hDEAD_BEEF, ok);
    add_entry(s + 32'hFFC,  1'b1, 4'b1111, 32'h0BAD_F00D, ok);
    add_entry(s,            1'b0, 4'b1111, 32'h0,         ok);
    add_entry(s + 32'h4,    1'b0, 4'b1111, 32'h0,         ok);
    add_entry(s + 32'hFFC,  1'b0, 4'b1111, 32'h0,         ok);
    add_entry(s,            1'b1, 4'b0101, 32'hAABB_CCDD, ok);
    add_entry(s + 32'h4,    1'b1, 4'b1000, 32'h5A00_0000, ok);
    add_entry(s + 32'h4,    1'b1, 4'b0010, 32'h1234_5678, ok);
    add_entry(s + 32'hFFC,  1'b1, 4'b0110, 32'hFFFF_FFFF, ok);
    add_entry(s,            1'b0, 4'b1111, 32'h0,         ok);
    add_entry(s + 32'h4,    1'b0, 4'b1111, 32'h0,         ok);
    add_entry(s + 32'hFFC,  1'b0, 4'b1111, 32'h0,         ok);
    // ROM reads and a rejected write
    add_entry(r,            1'b0, 4'b1111, 32'h0,         ok);
    add_entry(r + 32'h14,   1'b0, 4'b1111, 32'h0,         ok);
    add_entry(r + 32'h3C,   1'b0, 4'b1111, 32'h0,         ok);
    add_entry(r + 32'h14,   1'b1, 4'b1111, 32'hFFFF_0000, slv);
    add_entry(r + 32'h14,   1'b0, 4'b1111, 32'h0,         ok);
    // GPIO window and unmapped space
    add_entry(g,            1'b0, 4'b1111, 32'h0,         slv);
    add_entry(g + 32'h10,   1'b1, 4'b1111, 32'hCAFE_0001, slv);
    add_entry(g + 32'hFFC,  1'b0, 4'b1111, 32'h0,         slv);
    add_entry(32'h0,        1'b0, 4'b1111, 32'h0,         dec);
    add_entry(r + 32'h40,   1'b0, 4'b1111, 32'h0,         dec);
    add_entry(s + 32'h1000, 1'b1, 4'b1111, 32'h7777_7777, dec);
    add_entry(g + 32'h1000, 1'b0, 4'b1111, 32'h0,         dec);
    // Applied after the ndmreset pulse
    reset_at = n_entries;
    add_entry(s,            1'b0, 4'b1111, 32'h0,         ok);
    add_entry(s + 32'h4,    1'b0, 4'b1111, 32'h0,         ok);
    add_entry(r + 32'hC,    1'b0, 4'b1111, 32'h0,         ok);
    table_ready = 1'b1;
  endtask

  // ------------------------------
  // Bus transaction
  // ------------------------------
  task automatic run_entry(input int i);
    int          bp;
    int          lat;
    bp = $unsigned($random(seed)) % 4;
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= tbl_addr[i];
    req_we    <= tbl_we[i];
    req_be    <= tbl_be[i];
    req_wdata <= tbl_wdata[i];
    rsp_ready <= (bp == 0);
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    // Request transfers on this edge
    @(posedge clk);
    req_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      check_val($sformatf("req_ready_o entry %0d", i), req_ready, 0);
    end while (!rsp_valid && lat < 8);
    check_val($sformatf("rsp latency entry %0d", i), lat, RspLatency);
    check_val($sformatf("rsp_rdata_o entry %0d", i), rsp_rdata, tbl_exp_data[i]);
    check_val($sformatf("rsp_err_o entry %0d", i), rsp_err, tbl_exp_resp[i]);
    if (bp > 0) begin
      repeat (bp) begin
        @(negedge clk);
        check_val($sformatf("rsp_valid_o entry %0d", i), rsp_valid, 1);
        check_val($sformatf("rsp_rdata_o entry %0d", i), rsp_rdata, tbl_exp_data[i]);
        check_val($sformatf("rsp_err_o entry %0d", i), rsp_err, tbl_exp_resp[i]);
        check_val($sformatf("req_ready_o entry %0d", i), req_ready, 0);
      end
      @(posedge clk);
      rsp_ready <= 1'b1;
    end
    @(posedge clk);
    @(negedge clk);
    check_val($sformatf("rsp_valid_o entry %0d", i), rsp_valid, 0);
    check_val($sformatf("req_ready_o entry %0d", i), req_ready, 1);
  endtask

  task automatic pulse_ndmreset();
    @(posedge clk);
    ndmreset <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_val("req_ready_o", req_ready, 0);
      check_val("debug_req_o", debug_req_out, 1);
    end
    @(posedge clk);
    ndmreset <= 1'b0;
    // Delay counter keeps its zero value
    for (int k = 0; k <= ReleaseEdges; k++) begin
      @(negedge clk);
      check_val("req_ready_o", req_ready, (k >= ReleaseEdges));
      check_val("debug_req_o", debug_req_out, 1);
    end
  endtask

  initial begin : watchdog
    wait (table_ready);
    repeat (n_entries * 10 + 200) @(posedge clk);
    $display("Timeout: the test did not finish within %0d cycles", n_entries * 10 + 200);
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin : main
    rst_n     = 1'b0;
    ndmreset  = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_be    = '0;
    req_wdata = '0;
    rsp_ready = 1'b1;
    debug_req = 1'b1;
    debug_en  = 1'b1;
    build_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_val("req_ready_o", req_ready, 0);
    check_val("rsp_valid_o", rsp_valid, 0);
    @(posedge clk);
    rst_n <= 1'b1;
    // Debug window after power-on
    for (int k = 0; k <= harness_pkg::DEBUG_DELAY_CYCLES + 1; k++) begin
      @(negedge clk);
      check_val("debug_req_o", debug_req_out, (k >= harness_pkg::DEBUG_DELAY_CYCLES));
      check_val("req_ready_o", req_ready, (k >= ReleaseEdges));
      check_val("rsp_valid_o", rsp_valid, 0);
    end
    @(posedge clk);
    debug_en <= 1'b0;
    @(negedge clk);
    check_val("debug_req_o", debug_req_out, 0);
    @(posedge clk);
    debug_en  <= 1'b1;
    debug_req <= 1'b0;
    @(negedge clk);
    check_val("debug_req_o", debug_req_out, 0);
    @(posedge clk);
    debug_req <= 1'b1;
    @(negedge clk);
    check_val("debug_req_o", debug_req_out, 1);
    for (int i = 0; i < reset_at; i++) begin
      run_entry(i);
    end
    pulse_ndmreset();
    for (int i = reset_at; i < n_entries; i++) begin
      run_entry(i);
    end
    @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the SoC harness testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_harness -f sources.f ||
  { echo "Build failed"; exit 1; }
./obj_dir/Vtb_soc_harness > sim.log 2>&1
cat sim.log
! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: sources.f
design/harness_pkg.sv
design/debug_ctrl.sv
design/bus_router.sv
design/boot_rom.sv
design/sram_mem.sv
design/soc_harness_top.sv
dv/clk_gen.sv
dv/soc_harness_asserts.sv
dv/tb_soc_harness.sv
